// ==== source/core_cfg.svh ====
// fixed RV32I core values; reset PC must be word aligned, only mscratch exists as a CSR
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch after reset
`define CORE_RESET_PC 32'h0000_0000

// machine scratch register, the only implemented CSR
`define CORE_CSR_MSCRATCH 12'h340

`define CORE_NOP 32'h0000_0013 // addi x0, x0, 0

`endif

// ==== source/core_pkg.sv ====
// shared types for the single-cycle core; funct3-coded enums must keep their encodings
package core_pkg;

    typedef logic [31:0] word; // data, address or instruction
    typedef logic [4:0]  r;    // register index

    // encodings follow funct3 of OP / OP-IMM
    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SLL  = 3'b001,
        ALU_SLT  = 3'b010,
        ALU_SLTU = 3'b011,
        ALU_XOR  = 3'b100,
        ALU_SR   = 3'b101,
        ALU_OR   = 3'b110,
        ALU_AND  = 3'b111
    } alu_op_t;

    typedef enum logic [1:0] {
        A_ZERO,
        A_RS1,
        A_IMM
    } alu_a_mux_t;

    typedef enum logic [1:0] {
        B_RS2,
        B_IMM_EXT,
        B_PC
    } alu_b_mux_t;

    // funct3 of BRANCH with 010 and 011 unused
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_op_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10
    } mem_width_t;

    // funct3[1:0] of SYSTEM with the immediate forms folded in
    typedef enum logic [2:0] {
        CSR_RW = 3'b001,
        CSR_RS = 3'b010,
        CSR_RC = 3'b011
    } csr_t;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_DM,
        WB_PC_PLUS_4,
        WB_CSR
    } wb_mux_t;

endpackage

// ==== source/decoder.sv ====
// RV32I decoder; unknown opcodes, ECALL/EBREAK and FENCE decode as no-ops
`timescale 1ns/100ps

module decoder (
    input  core_pkg::word        instr,
    output core_pkg::r           rs1,
    output core_pkg::r           rs2,
    output core_pkg::r           rd,
    output core_pkg::word        imm,
    output logic                 branch_always,
    output logic                 branch_instr,
    output core_pkg::branch_op_t branch_op,
    output core_pkg::alu_a_mux_t alu_a_mux_sel,
    output core_pkg::alu_b_mux_t alu_b_mux_sel,
    output core_pkg::alu_op_t    alu_op,
    output logic                 sub_arith,
    output logic                 dmem_write_enable,
    output logic                 dmem_sign_extend,
    output core_pkg::mem_width_t dmem_width,
    output logic                 csr_enable,
    output core_pkg::csr_t       csr_op,
    output logic [11:0]          csr_addr,
    output logic                 csr_use_imm,
    output core_pkg::wb_mux_t    wb_mux_sel,
    output logic                 wb_write_enable
);
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_ALUI   = 7'b0010011;
    localparam logic [6:0] OP_ALU    = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign rd       = instr[11:7];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign csr_addr = instr[31:20];

    always_comb begin
        // defaults leave the core idle
        imm               = '0;
        branch_always     = 1'b0;
        branch_instr      = 1'b0;
        branch_op         = core_pkg::branch_op_t'(funct3);
        alu_a_mux_sel     = core_pkg::A_RS1;
        alu_b_mux_sel     = core_pkg::B_IMM_EXT;
        alu_op            = core_pkg::ALU_ADD;
        sub_arith         = 1'b0;
        dmem_write_enable = 1'b0;
        dmem_sign_extend  = ~funct3[2];
        dmem_width        = core_pkg::mem_width_t'(funct3[1:0]);
        csr_enable        = 1'b0;
        csr_op            = core_pkg::csr_t'({1'b0, funct3[1:0]});
        csr_use_imm       = funct3[2];
        wb_mux_sel        = core_pkg::WB_ALU;
        wb_write_enable   = 1'b0;

        case (opcode)
            OP_LUI: begin
                imm             = {instr[31:12], 12'b0};
                alu_a_mux_sel   = core_pkg::A_ZERO; // 0 | imm
                alu_op          = core_pkg::ALU_OR;
                wb_write_enable = 1'b1;
            end
            OP_AUIPC: begin
                imm             = {instr[31:12], 12'b0};
                alu_a_mux_sel   = core_pkg::A_IMM;
                alu_b_mux_sel   = core_pkg::B_PC;
                wb_write_enable = 1'b1;
            end
            OP_JAL: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
                alu_a_mux_sel   = core_pkg::A_IMM; // target pc + imm
                alu_b_mux_sel   = core_pkg::B_PC;
                branch_always   = 1'b1;
                wb_mux_sel      = core_pkg::WB_PC_PLUS_4;
                wb_write_enable = 1'b1;
            end
            OP_JALR: begin
                imm             = {{20{instr[31]}}, instr[31:20]};
                branch_always   = 1'b1; // target rs1 + imm
                wb_mux_sel      = core_pkg::WB_PC_PLUS_4;
                wb_write_enable = 1'b1;
            end
            OP_BRANCH: begin
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                alu_a_mux_sel = core_pkg::A_IMM;
                alu_b_mux_sel = core_pkg::B_PC;
                branch_instr  = 1'b1;
            end
            OP_LOAD: begin
                imm             = {{20{instr[31]}}, instr[31:20]};
                wb_mux_sel      = core_pkg::WB_DM;
                wb_write_enable = 1'b1;
            end
            OP_STORE: begin
                imm               = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                dmem_write_enable = 1'b1;
            end
            OP_ALUI: begin
                imm             = {{20{instr[31]}}, instr[31:20]};
                alu_op          = core_pkg::alu_op_t'(funct3);
                sub_arith       = (funct3 == 3'b101) & instr[30]; // srai only
                wb_write_enable = 1'b1;
            end
            OP_ALU: begin
                alu_b_mux_sel   = core_pkg::B_RS2;
                alu_op          = core_pkg::alu_op_t'(funct3);
                sub_arith       = instr[30]; // sub, sra
                wb_write_enable = 1'b1;
            end
            OP_FENCE: begin
                // single-cycle with in-order memory, nothing to order
            end
            OP_SYSTEM: begin
                if (funct3[1:0] != 2'b00) begin // ecall/ebreak fall through
                    csr_enable      = 1'b1;
                    wb_mux_sel      = core_pkg::WB_CSR;
                    wb_write_enable = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== source/register_file.sv ====
// 32 x 32 integer registers, combinational reads, x0 always reads zero
`timescale 1ns/100ps

module register_file (
    input  logic          clk,
    input  logic          reset,
    input  core_pkg::r    rs1,
    input  core_pkg::r    rs2,
    input  core_pkg::r    rd,
    input  core_pkg::word rd_data,
    input  logic          write_enable,
    output core_pkg::word rs1_data,
    output core_pkg::word rs2_data
);
    core_pkg::word regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != 5'd0) begin
            regs[rd] <= rd_data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== source/alu.sv ====
// combinational RV32I ALU; shift amount taken from the low five bits of operand b
`timescale 1ns/100ps

module alu (
    input  core_pkg::word        rs1_data,
    input  core_pkg::word        rs2_data,
    input  core_pkg::word        imm,
    input  core_pkg::word        pc,
    input  core_pkg::alu_a_mux_t alu_a_mux_sel,
    input  core_pkg::alu_b_mux_t alu_b_mux_sel,
    input  core_pkg::alu_op_t    alu_op,
    input  logic                 sub_arith,
    output core_pkg::word        result
);
    core_pkg::word a;
    core_pkg::word b;
    logic [4:0]    shamt;

    always_comb begin
        case (alu_a_mux_sel)
            core_pkg::A_RS1: a = rs1_data;
            core_pkg::A_IMM: a = imm;
            default:         a = '0;
        endcase
        case (alu_b_mux_sel)
            core_pkg::B_RS2:     b = rs2_data;
            core_pkg::B_IMM_EXT: b = imm;
            default:             b = pc;
        endcase
    end

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD:  result = sub_arith ? a - b : a + b;
            core_pkg::ALU_SLL:  result = a << shamt;
            core_pkg::ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            core_pkg::ALU_SLTU: result = {31'b0, a < b};
            core_pkg::ALU_XOR:  result = a ^ b;
            core_pkg::ALU_SR:   result = sub_arith ? core_pkg::word'($signed(a) >>> shamt)
                                                   : a >> shamt;
            core_pkg::ALU_OR:   result = a | b;
            default:            result = a & b; // ALU_AND
        endcase
    end

endmodule

// ==== source/branch_logic.sv ====
// branch compare and next PC; jump targets come from the ALU with bit 0 cleared
`timescale 1ns/100ps

module branch_logic (
    input  core_pkg::word        rs1_data,
    input  core_pkg::word        rs2_data,
    input  core_pkg::branch_op_t branch_op,
    input  logic                 branch_instr,
    input  logic                 branch_always,
    input  core_pkg::word        pc,
    input  core_pkg::word        alu_result,
    output core_pkg::word        next_pc
);
    logic cond;

    always_comb begin
        case (branch_op)
            core_pkg::BEQ:  cond = rs1_data == rs2_data;
            core_pkg::BNE:  cond = rs1_data != rs2_data;
            core_pkg::BLT:  cond = $signed(rs1_data) < $signed(rs2_data);
            core_pkg::BGE:  cond = $signed(rs1_data) >= $signed(rs2_data);
            core_pkg::BLTU: cond = rs1_data < rs2_data;
            core_pkg::BGEU: cond = rs1_data >= rs2_data;
            default:        cond = 1'b0; // reserved funct3 is never taken
        endcase
    end

    assign next_pc = ((branch_instr && cond) || branch_always) ? {alu_result[31:1], 1'b0}
                                                               : pc + 32'd4;

endmodule

// ==== source/load_store_unit.sv ====
// byte lane steering for the data bus; misaligned halves and words are not handled
`timescale 1ns/100ps

module load_store_unit (
    input  core_pkg::word        addr,
    input  core_pkg::word        rs2_data,
    input  core_pkg::mem_width_t dmem_width,
    input  logic                 dmem_sign_extend,
    input  core_pkg::word        mem_rdata,
    output logic [3:0]           byte_en,
    output core_pkg::word        wdata,
    output core_pkg::word        load_data
);
    core_pkg::word shifted;

    // selected lane moved down to bit 0
    assign shifted = mem_rdata >> {addr[1:0], 3'b000};

    always_comb begin
        case (dmem_width)
            core_pkg::MEM_BYTE: begin
                byte_en = 4'b0001 << addr[1:0];
                wdata   = {4{rs2_data[7:0]}}; // every lane carries the byte
            end
            core_pkg::MEM_HALF: begin
                byte_en = 4'b0011 << {addr[1], 1'b0};
                wdata   = {2{rs2_data[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                wdata   = rs2_data;
            end
        endcase
    end

    always_comb begin
        case (dmem_width)
            core_pkg::MEM_BYTE:
                load_data = {{24{dmem_sign_extend & shifted[7]}}, shifted[7:0]};
            core_pkg::MEM_HALF:
                load_data = {{16{dmem_sign_extend & shifted[15]}}, shifted[15:0]};
            default:
                load_data = mem_rdata;
        endcase
    end

endmodule

// ==== source/csr_file.sv ====
// mscratch only; every other CSR address reads zero and ignores writes
`timescale 1ns/100ps
`include "core_cfg.svh"

module csr_file (
    input  logic           clk,
    input  logic           reset,
    input  logic           csr_enable,
    input  core_pkg::csr_t csr_op,
    input  logic [11:0]    csr_addr,
    input  core_pkg::word  wdata,
    input  logic           write_block,
    output core_pkg::word  rdata
);
    core_pkg::word mscratch;
    core_pkg::word new_value;
    logic          hit;
    logic          do_write;

    assign hit = csr_addr == `CORE_CSR_MSCRATCH;

    always_comb begin
        case (csr_op)
            core_pkg::CSR_RW: new_value = wdata;
            core_pkg::CSR_RS: new_value = mscratch | wdata;
            core_pkg::CSR_RC: new_value = mscratch & ~wdata;
            default:          new_value = mscratch;
        endcase
    end

    // set and clear with a zero operand leave the register alone
    assign do_write = csr_enable && hit && !write_block &&
                      (csr_op == core_pkg::CSR_RW || wdata != '0);

    always_ff @(posedge clk) begin
        if (reset)
            mscratch <= '0;
        else if (do_write)
            mscratch <= new_value;
    end

    assign rdata = hit ? mscratch : '0; // old value before the edge

endmodule

// ==== source/core_top.sv ====
// single-cycle RV32I core; memories answer in the same cycle, no traps or interrupts
`timescale 1ns/100ps
`include "core_cfg.svh"

module core_top (
    input  logic          clk,
    input  logic          reset,
    input  core_pkg::word instr,
    output core_pkg::word imem_addr,
    output core_pkg::word dmem_addr,
    output core_pkg::word dmem_wdata,
    output logic [3:0]    dmem_byte_en,
    output logic          dmem_write_enable,
    input  core_pkg::word dmem_rdata
);
    core_pkg::word        pc;
    core_pkg::word        next_pc;
    core_pkg::word        pc_plus_4;
    core_pkg::r           rs1;
    core_pkg::r           rs2;
    core_pkg::r           rd;
    core_pkg::word        imm;
    logic                 branch_always;
    logic                 branch_instr;
    core_pkg::branch_op_t branch_op;
    core_pkg::alu_a_mux_t alu_a_mux_sel;
    core_pkg::alu_b_mux_t alu_b_mux_sel;
    core_pkg::alu_op_t    alu_op;
    logic                 sub_arith;
    logic                 store;
    logic                 dmem_sign_extend;
    core_pkg::mem_width_t dmem_width;
    logic                 csr_enable;
    core_pkg::csr_t       csr_op;
    logic [11:0]          csr_addr;
    logic                 csr_use_imm;
    core_pkg::wb_mux_t    wb_mux_sel;
    logic                 wb_write_enable;
    core_pkg::word        rs1_data;
    core_pkg::word        rs2_data;
    core_pkg::word        rd_data;
    core_pkg::word        alu_result;
    core_pkg::word        load_data;
    core_pkg::word        csr_wdata;
    core_pkg::word        csr_rdata;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= `CORE_RESET_PC;
        else
            pc <= next_pc;
    end

    assign imem_addr  = pc;
    assign pc_plus_4  = pc + 32'd4;

    decoder u_decoder (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .branch_always(branch_always), .branch_instr(branch_instr), .branch_op(branch_op),
        .alu_a_mux_sel(alu_a_mux_sel), .alu_b_mux_sel(alu_b_mux_sel), .alu_op(alu_op),
        .sub_arith(sub_arith), .dmem_write_enable(store),
        .dmem_sign_extend(dmem_sign_extend), .dmem_width(dmem_width),
        .csr_enable(csr_enable), .csr_op(csr_op), .csr_addr(csr_addr),
        .csr_use_imm(csr_use_imm), .wb_mux_sel(wb_mux_sel), .wb_write_enable(wb_write_enable)
    );

    register_file u_register_file (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd), .rd_data(rd_data),
        .write_enable(wb_write_enable & ~reset), .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu u_alu (
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm), .pc(pc),
        .alu_a_mux_sel(alu_a_mux_sel), .alu_b_mux_sel(alu_b_mux_sel), .alu_op(alu_op),
        .sub_arith(sub_arith), .result(alu_result)
    );

    branch_logic u_branch_logic (
        .rs1_data(rs1_data), .rs2_data(rs2_data), .branch_op(branch_op),
        .branch_instr(branch_instr), .branch_always(branch_always), .pc(pc),
        .alu_result(alu_result), .next_pc(next_pc)
    );

    assign dmem_addr         = alu_result; // rs1 + imm for loads and stores
    assign dmem_write_enable = store & ~reset;

    load_store_unit u_load_store_unit (
        .addr(alu_result), .rs2_data(rs2_data), .dmem_width(dmem_width),
        .dmem_sign_extend(dmem_sign_extend), .mem_rdata(dmem_rdata),
        .byte_en(dmem_byte_en), .wdata(dmem_wdata), .load_data(load_data)
    );

    // csrr*i use the rs1 field as a 5-bit immediate
    assign csr_wdata = csr_use_imm ? {27'b0, rs1} : rs1_data;

    csr_file u_csr_file (
        .clk(clk), .reset(reset), .csr_enable(csr_enable), .csr_op(csr_op),
        .csr_addr(csr_addr), .wdata(csr_wdata), .write_block(reset), .rdata(csr_rdata)
    );

    always_comb begin
        case (wb_mux_sel)
            core_pkg::WB_DM:        rd_data = load_data;
            core_pkg::WB_PC_PLUS_4: rd_data = pc_plus_4; // link address
            core_pkg::WB_CSR:       rd_data = csr_rdata;
            default:                rd_data = alu_result;
        endcase
    end

endmodule

// ==== sim/tb_core.sv ====
// core testbench; both memories are 1 KiB, answer combinationally, and the program must fit in them
`timescale 1ns/100ps
`include "core_cfg.svh"

module tb_core;
    localparam int         TIMEOUT   = 2000; // cycles allowed per expected store
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    logic          clk;
    logic          reset;
    core_pkg::word instr;
    core_pkg::word imem_addr;
    core_pkg::word dmem_addr;
    core_pkg::word dmem_wdata;
    logic [3:0]    dmem_byte_en;
    logic          dmem_write_enable;
    core_pkg::word dmem_rdata;

    core_pkg::word prog [256];
    core_pkg::word dmem [256];

    // expected stores in program order
    string         exp_name [$];
    core_pkg::word exp_pc [$];
    core_pkg::word exp_addr [$];
    core_pkg::word exp_data [$];
    logic [3:0]    exp_be [$];

    core_pkg::word build_pc;   // address of the next emitted instruction
    logic [11:0]   result_off; // offset from x10 for the next result word
    core_pkg::word not_taken;
    core_pkg::word csr_val;    // mscratch as the rules predict it

    core_top dut (
        .clk(clk), .reset(reset), .instr(instr), .imem_addr(imem_addr),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_byte_en(dmem_byte_en),
        .dmem_write_enable(dmem_write_enable), .dmem_rdata(dmem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign instr      = (imem_addr < 32'h400) ? prog[imem_addr[9:2]] : `CORE_NOP;
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (dmem_write_enable) begin
            for (int k = 0; k < 4; k++) begin
                if (dmem_byte_en[k])
                    dmem[dmem_addr[9:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
            end
        end
    end

    function automatic core_pkg::word lcg_next(input core_pkg::word state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic core_pkg::word r_type(input logic [6:0] f7, input core_pkg::r rs2,
                                             input core_pkg::r rs1, input logic [2:0] f3,
                                             input core_pkg::r rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::word i_type(input logic [11:0] imm, input core_pkg::r rs1,
                                             input logic [2:0] f3, input core_pkg::r rd,
                                             input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic core_pkg::word s_type(input logic [11:0] imm, input core_pkg::r rs2,
                                             input core_pkg::r rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic core_pkg::word b_type(input logic [12:0] imm, input core_pkg::r rs2,
                                             input core_pkg::r rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic core_pkg::word u_type(input logic [19:0] imm, input core_pkg::r rd,
                                             input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic core_pkg::word j_type(input logic [20:0] imm, input core_pkg::r rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // load result from the filled memory by the RV32I extension rules
    function automatic core_pkg::word load_value(input core_pkg::word addr,
                                                 input logic [2:0] f3);
        core_pkg::word lanes;
        lanes = dmem[addr[9:2]] >> {addr[1:0], 3'b000};
        case (f3)
            3'b000:  return {{24{lanes[7]}}, lanes[7:0]};
            3'b100:  return {24'b0, lanes[7:0]};
            3'b001:  return {{16{lanes[15]}}, lanes[15:0]};
            3'b101:  return {16'b0, lanes[15:0]};
            default: return dmem[addr[9:2]];
        endcase
    endfunction

    task automatic compare(input string name, input core_pkg::word expected,
                           input core_pkg::word actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            $display("Finished with errors");
            $fatal(1, "check failed");
        end
    endtask

    task automatic emit(input core_pkg::word w);
        prog[build_pc[9:2]] = w;
        build_pc = build_pc + 32'd4;
    endtask

    task automatic expect_store(input string name, input core_pkg::word addr,
                                input core_pkg::word data, input logic [3:0] be);
        exp_name.push_back(name);
        exp_pc.push_back(build_pc); // the store itself is emitted next
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_be.push_back(be);
    endtask

    task automatic store_result(input string name, input core_pkg::r src,
                                input core_pkg::word value);
        expect_store(name, 32'h100 + {20'b0, result_off}, value, 4'hF);
        emit(s_type(result_off, src, 5'd10, 3'b010));
        result_off = result_off + 12'd4;
    endtask

    task automatic reg_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input core_pkg::word value);
        emit(r_type(f7, 5'd2, 5'd1, f3, 5'd3));
        store_result(name, 5'd3, value);
    endtask

    task automatic imm_op(input string name, input logic [11:0] imm, input logic [2:0] f3,
                          input core_pkg::word value);
        emit(i_type(imm, 5'd1, f3, 5'd3, OP_IMM));
        store_result(name, 5'd3, value);
    endtask

    // store to an address no row expects, so executing it fails the next check
    task automatic skip_slot();
        emit(s_type(12'h3F0, 5'd0, 5'd0, 3'b010));
    endtask

    task automatic branch_case(input logic [2:0] f3, input core_pkg::r rs1,
                               input core_pkg::r rs2, input logic taken);
        emit(b_type(13'd8, rs2, rs1, f3));
        if (taken) begin
            skip_slot();
        end else begin
            emit(i_type(12'd1, 5'd5, 3'b000, 5'd5, OP_IMM));
            not_taken = not_taken + 32'd1;
        end
    endtask

    task automatic load_case(input string name, input logic [2:0] f3, input logic [11:0] addr);
        emit(i_type(addr, 5'd0, f3, 5'd11, OP_LOAD));
        store_result($sformatf("%s @%0h", name, addr), 5'd11, load_value({20'b0, addr}, f3));
    endtask

    task automatic lane_store(input logic [2:0] f3, input logic [11:0] addr,
                              input logic [3:0] be, input core_pkg::word data);
        expect_store($sformatf("store f3=%0d @%0h", f3, addr), {20'b0, addr}, data, be);
        emit(s_type(addr, 5'd12, 5'd0, f3));
    endtask

    task automatic csr_case(input string name, input logic [2:0] f3, input core_pkg::r src,
                            input core_pkg::word operand);
        core_pkg::word old;
        old = csr_val;
        emit(i_type(`CORE_CSR_MSCRATCH, src, f3, 5'd13, OP_SYSTEM));
        case (f3[1:0])
            2'b01:   csr_val = operand;
            2'b10:   csr_val = csr_val | operand;
            default: csr_val = csr_val & ~operand;
        endcase
        store_result(name, 5'd13, old);
    endtask

    task automatic check_store(input int i);
        logic [3:0]    be;
        core_pkg::word mask;
        be   = exp_be[i];
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        compare({exp_name[i], " pc"}, exp_pc[i], imem_addr);
        compare({exp_name[i], " addr"}, exp_addr[i], dmem_addr);
        compare({exp_name[i], " byte enable"}, {28'b0, be}, {28'b0, dmem_byte_en});
        compare({exp_name[i], " data"}, exp_data[i] & mask, dmem_wdata & mask);
    endtask

    initial begin
        core_pkg::word a;
        core_pkg::word b;
        core_pkg::word mark;
        int            waited;
        reset = 1'b1;
        mark  = 32'h9e23_f6b4;
        for (int i = 0; i < 256; i++) begin
            mark    = lcg_next(mark);
            dmem[i] = mark;
            prog[i] = `CORE_NOP;
        end
        build_pc   = `CORE_RESET_PC;
        result_off = 12'h000;
        // fetched during reset and stored only once reset is low
        emit(s_type(12'h3F8, 5'd0, 5'd0, 3'b010));
        emit(i_type(12'h100, 5'd0, 3'b000, 5'd10, OP_IMM)); // x10 result base
        emit(i_type(12'hFF9, 5'd0, 3'b000, 5'd1, OP_IMM));
        emit(i_type(12'h005, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit(i_type(12'h3F8, 5'd0, 3'b010, 5'd11, OP_LOAD));
        store_result("reset slot", 5'd11, 32'd0); // zero from the first store
        a = 32'hFFFF_FFF9;
        b = 32'd5;
        reg_op("add", 7'h00, 3'b000, 32'hFFFF_FFFE);
        reg_op("sub", 7'h20, 3'b000, 32'hFFFF_FFF4);
        reg_op("sll", 7'h00, 3'b001, 32'hFFFF_FF20);
        reg_op("slt", 7'h00, 3'b010, 32'd1); // -7 < 5 signed
        reg_op("sltu", 7'h00, 3'b011, 32'd0);
        reg_op("xor", 7'h00, 3'b100, 32'hFFFF_FFFC);
        reg_op("srl", 7'h00, 3'b101, 32'h07FF_FFFF);
        reg_op("sra", 7'h20, 3'b101, 32'hFFFF_FFFF);
        reg_op("or", 7'h00, 3'b110, 32'hFFFF_FFFD);
        reg_op("and", 7'h00, 3'b111, 32'h0000_0001);
        imm_op("addi", 12'hFFA, 3'b000, 32'hFFFF_FFF3); // bit 30 set yet still an add
        imm_op("slti", 12'hFFA, 3'b010, 32'd1);
        imm_op("sltiu", 12'hFFF, 3'b011, 32'd1);
        imm_op("xori", 12'h0F0, 3'b100, 32'hFFFF_FF09);
        imm_op("ori", 12'h0F0, 3'b110, 32'hFFFF_FFF9);
        imm_op("andi", 12'h7F3, 3'b111, 32'h0000_07F1);
        imm_op("slli", 12'h003, 3'b001, 32'hFFFF_FFC8);
        imm_op("srli", 12'h003, 3'b101, 32'h1FFF_FFFF);
        imm_op("srai", 12'h403, 3'b101, 32'hFFFF_FFFF);
        emit(u_type(20'hFEDCB, 5'd4, OP_LUI));
        store_result("lui", 5'd4, 32'hFEDC_B000);
        mark = build_pc;
        emit(u_type(20'h00001, 5'd4, OP_AUIPC));
        store_result("auipc", 5'd4, mark + 32'h0000_1000);

        // x5 counts the branches that fall through
        emit(i_type(12'h000, 5'd0, 3'b000, 5'd5, OP_IMM));
        not_taken = 32'd0;
        branch_case(3'b000, 5'd1, 5'd1, 1'b1);
        branch_case(3'b000, 5'd1, 5'd2, 1'b0);
        branch_case(3'b001, 5'd1, 5'd2, 1'b1);
        branch_case(3'b001, 5'd1, 5'd1, 1'b0);
        branch_case(3'b100, 5'd1, 5'd2, 1'b1); // -7 < 5
        branch_case(3'b100, 5'd2, 5'd1, 1'b0);
        branch_case(3'b101, 5'd2, 5'd1, 1'b1);
        branch_case(3'b101, 5'd1, 5'd2, 1'b0);
        branch_case(3'b110, 5'd2, 5'd1, 1'b1); // -7 is large as unsigned
        branch_case(3'b110, 5'd1, 5'd2, 1'b0);
        branch_case(3'b111, 5'd1, 5'd2, 1'b1);
        branch_case(3'b111, 5'd2, 5'd1, 1'b0);
        store_result("branch fall-through count", 5'd5, not_taken);
        mark = build_pc;
        emit(j_type(21'd8, 5'd7));
        skip_slot();
        store_result("jal link", 5'd7, mark + 32'd4);
        mark = build_pc;
        emit(u_type(20'h00000, 5'd8, OP_AUIPC));
        emit(i_type(12'd13, 5'd8, 3'b000, 5'd9, OP_JALR)); // odd target lands on +12
        skip_slot();
        store_result("jalr link", 5'd9, mark + 32'd8);
        emit(32'h0000_000F); // fence

        for (int w = 12; w <= 28; w += 16) begin
            for (int k = 0; k < 4; k++) begin
                load_case("lb", 3'b000, 12'(w + k));
                load_case("lbu", 3'b100, 12'(w + k));
            end
            for (int k = 0; k < 4; k += 2) begin
                load_case("lh", 3'b001, 12'(w + k));
                load_case("lhu", 3'b101, 12'(w + k));
            end
            load_case("lw", 3'b010, 12'(w));
        end

        emit(u_type(20'hA1B2C, 5'd12, OP_LUI));
        emit(i_type(12'h3D4, 5'd12, 3'b000, 5'd12, OP_IMM));
        mark = 32'hA1B2_C3D4;
        for (int k = 0; k < 4; k++)
            lane_store(3'b000, 12'(32'h200 + k), 4'b0001 << k, {4{mark[7:0]}});
        for (int k = 0; k < 4; k += 2)
            lane_store(3'b001, 12'(32'h210 + k), 4'b0011 << k, {2{mark[15:0]}});

        csr_val = 32'd0; // mscratch clears on reset
        csr_case("csrrw", 3'b001, 5'd1, a);
        csr_case("csrrs", 3'b010, 5'd2, b);
        csr_case("csrrc", 3'b011, 5'd1, a);
        csr_case("csrrs x0", 3'b010, 5'd0, 32'd0);
        csr_case("csrrwi", 3'b101, 5'h1F, 32'h1F);
        csr_case("csrrci", 3'b111, 5'h03, 32'h03);
        csr_case("csrrsi", 3'b110, 5'h00, 32'h00);

        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            compare("reset pc", `CORE_RESET_PC, imem_addr);
            compare("reset store", 32'd0, {31'b0, dmem_write_enable});
        end
        reset = 1'b0;

        for (int i = 0; i < exp_addr.size(); i++) begin
            waited = 0;
            @(negedge clk);
            while (!dmem_write_enable) begin
                if (waited >= TIMEOUT) begin
                    $display("Timeout: the store '%s' never came", exp_name[i]);
                    $display("Finished with errors");
                    $fatal(1, "store wait timed out");
                end else begin
                    waited++;
                    @(negedge clk);
                end
            end
            check_store(i);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== rv32_core.f ====
+incdir+source
source/core_pkg.sv
source/decoder.sv
source/register_file.sv
source/alu.sv
source/branch_logic.sv
source/load_store_unit.sv
source/csr_file.sv
source/core_top.sv
sim/tb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the core testbench with Verilator and runs it; exit status follows the simulation
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f rv32_core.f \
    --top-module tb_core -o sim_tb_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_tb_core
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation run passed"
exit 0
